// ==== common/posit_defs.svh ====
// Posit accumulator parameters
// Word format, running-sum precision and pipeline latency

`ifndef POSIT_DEFS_SVH
`define POSIT_DEFS_SVH

// Posit word width
`define POSIT_NBITS 32

// Exponent field width (es)
`define POSIT_ES 2

// Running-sum fraction bits, hidden bit not counted
`define ACC_FBITS 64

// Signed scale width, leaves headroom above the posit range
`define ACC_SBITS 10

// Largest finite scale, (NBITS - 2) * 2^es; the smallest is its negative
`define POSIT_MAX_SCALE 120

// Start sampling edge to done raising edge
`define ACC_LATENCY 6

`endif

// ==== common/posit_pkg.sv ====
// Posit accumulator shared types
// Posit word, decoded value, aligned operand pair and raw adder sum

`include "posit_defs.svh"

package posit_pkg;

    typedef logic [`POSIT_NBITS-1:0] posit_t;

    // Decoded posit or running sum, hidden bit implied unless zero
    typedef struct packed {
        logic                         sign;
        logic signed [`ACC_SBITS-1:0] scale;
        logic [`ACC_FBITS-1:0]        fraction;
        logic                         zero;
        logic                         nar;
    } unpacked_t;

    // Larger operand kept whole, smaller one already shifted to its scale
    typedef struct packed {
        unpacked_t             big;
        logic                  small_hidden;
        logic [`ACC_FBITS-1:0] small_frac;
        logic                  sticky;        // Bits lost in the shift
        logic                  sub;           // Signs differ
    } aligned_t;

    // Adder output before normalization
    typedef struct packed {
        logic                         sign;
        logic signed [`ACC_SBITS-1:0] scale;
        logic [`ACC_FBITS+1:0]        frac;     // Carry, hidden bit, fraction
        logic                         sticky;
        logic                         zero;
        logic                         nar;
    } rawsum_t;

endpackage

// ==== design/posit_decode.sv ====
// Posit decoder
// Splits a posit word into sign, scale and left-aligned fraction, one cycle

`include "posit_defs.svh"

module posit_decode
    import posit_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      in_valid,
    input  posit_t    operand,
    output logic      out_valid,
    output unpacked_t value
);

    localparam int NB = `POSIT_NBITS;
    localparam int ES = `POSIT_ES;
    localparam int FB = `ACC_FBITS;
    localparam int SB = `ACC_SBITS;
    localparam int PF = NB - 1 - ES;     // Fraction bits left after a minimal regime
    localparam int KW = $clog2(NB) + 1;

    posit_t               mag;
    logic [NB-2:0]        body;
    logic [NB-2:0]        run;
    logic [NB-2:0]        rest;
    logic [KW-1:0]        k;
    logic signed [SB-1:0] regime;
    unpacked_t            dec;

    always_comb
    begin
        mag  = operand[NB-1] ? -operand : operand;
        body = mag[NB-2:0];
        run  = body[NB-2] ? ~body : body;    // Regime run becomes leading zeros

        // Run length, the last hit is the highest set bit
        k = KW'(NB - 1);
        for (int i = 0; i < NB - 1; i++)
        begin
            if (run[i])
                k = KW'(NB - 2 - i);
        end

        if (body[NB-2])
            regime = SB'(k) - SB'(1);
        else
            regime = -SB'(k);

        rest = body << (k + 1);              // Drop regime and its terminating bit

        dec.sign     = operand[NB-1];
        dec.scale    = (regime <<< ES) + SB'(rest[NB-2 -: ES]);
        dec.fraction = {rest[PF-1:0], {(FB - PF){1'b0}}};
        dec.zero     = (operand == '0);
        dec.nar      = (operand == {1'b1, {(NB - 1){1'b0}}});

        if (dec.zero || dec.nar)
        begin
            dec.sign     = 1'b0;
            dec.scale    = '0;
            dec.fraction = '0;
        end
    end

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            out_valid <= 1'b0;
        else
            out_valid <= in_valid;
    end

    always_ff @(posedge clk)
    begin
        value <= dec;
    end

endmodule

// ==== accum/accum_align.sv ====
// Accumulator alignment stage
// Orders operand and running sum by magnitude and shifts the smaller one right

`include "posit_defs.svh"

module accum_align
    import posit_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      in_valid,
    input  unpacked_t operand,
    input  unpacked_t sum,
    output logic      out_valid,
    output aligned_t  aligned
);

    localparam int FB = `ACC_FBITS;
    localparam int SB = `ACC_SBITS;
    localparam int DW = $clog2(FB + 2);

    logic          op_bigger;
    unpacked_t     big;
    unpacked_t     lesser;
    logic [SB-1:0] diff;
    logic [DW-1:0] shamt;
    logic [2*FB:0] ext;
    aligned_t      aln;

    always_comb
    begin
        // A zero operand always counts as the smaller one
        if (sum.zero)
            op_bigger = 1'b1;
        else if (operand.zero)
            op_bigger = 1'b0;
        else if (operand.scale != sum.scale)
            op_bigger = $signed(operand.scale) > $signed(sum.scale);
        else
            op_bigger = operand.fraction >= sum.fraction;

        big    = op_bigger ? operand : sum;
        lesser = op_bigger ? sum : operand;

        // Saturates once the hidden bit has left the kept half
        diff  = big.scale - lesser.scale;
        shamt = (diff > SB'(FB + 1)) ? DW'(FB + 1) : DW'(diff);
        ext   = {~lesser.zero, lesser.fraction, {FB{1'b0}}} >> shamt;

        aln.big          = big;
        aln.big.nar      = operand.nar | sum.nar;   // NaR from either side sticks
        aln.small_hidden = ext[2*FB];
        aln.small_frac   = ext[2*FB-1:FB];
        aln.sticky       = |ext[FB-1:0];
        aln.sub          = operand.sign ^ sum.sign;
    end

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            out_valid <= 1'b0;
        else
            out_valid <= in_valid;
    end

    always_ff @(posedge clk)
    begin
        aligned <= aln;
    end

endmodule

// ==== accum/accum_addsub.sv ====
// Accumulator add/subtract and normalize
// Fraction add or subtract, then leading-one normalization, one register each

`include "posit_defs.svh"

module accum_addsub
    import posit_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      in_valid,
    input  aligned_t  aligned,
    output logic      out_valid,
    output unpacked_t sum,
    output logic      sticky
);

    localparam int FB = `ACC_FBITS;
    localparam int SB = `ACC_SBITS;
    localparam int LW = $clog2(FB + 2);

    rawsum_t       raw_d;
    rawsum_t       raw_q;
    logic          raw_valid;
    logic [FB+1:0] op_big;
    logic [FB+1:0] op_small;
    logic [LW-1:0] lz;
    logic [FB:0]   norm;
    unpacked_t     sum_d;
    logic          sticky_d;

    // Stage one, magnitudes are ordered so the difference never goes negative
    always_comb
    begin
        op_big   = {1'b0, ~aligned.big.zero, aligned.big.fraction};
        op_small = {1'b0, aligned.small_hidden, aligned.small_frac};

        raw_d.frac   = aligned.sub ? op_big - op_small : op_big + op_small;
        raw_d.sign   = aligned.big.sign;
        raw_d.scale  = aligned.big.scale;
        raw_d.sticky = aligned.sticky;
        raw_d.zero   = aligned.big.zero;
        raw_d.nar    = aligned.big.nar;
    end

    // Stage two
    always_comb
    begin
        lz = LW'(FB + 1);
        for (int i = 0; i <= FB; i++)
        begin
            if (raw_q.frac[i])
                lz = LW'(FB - i);
        end
        norm = raw_q.frac[FB:0] << lz;

        sum_d.sign = raw_q.sign;
        sum_d.zero = 1'b0;
        sum_d.nar  = raw_q.nar;
        sticky_d   = raw_q.sticky;

        if (raw_q.frac[FB+1])                // Carry out, one step right
        begin
            sum_d.scale    = raw_q.scale + SB'(1);
            sum_d.fraction = raw_q.frac[FB:1];
            sticky_d       = raw_q.sticky | raw_q.frac[0];
        end
        else
        begin
            sum_d.scale    = raw_q.scale - SB'(lz);
            sum_d.fraction = norm[FB-1:0];
        end

        // Exact cancellation comes out as positive zero
        if (raw_q.nar || raw_q.zero || raw_q.frac == '0)
        begin
            sum_d.sign     = 1'b0;
            sum_d.scale    = '0;
            sum_d.fraction = '0;
            sum_d.zero     = ~raw_q.nar;
            sticky_d       = 1'b0;
        end
    end

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            raw_valid <= 1'b0;
            out_valid <= 1'b0;
        end
        else
        begin
            raw_valid <= in_valid;
            out_valid <= raw_valid;
        end
    end

    always_ff @(posedge clk)
    begin
        raw_q  <= raw_d;
        sum    <= sum_d;
        sticky <= sticky_d;
    end

endmodule

// ==== design/posit_encode.sv ====
// Posit encoder
// Rounds the running sum to nearest-even and packs it, saturating at maxpos and minpos

`include "posit_defs.svh"

module posit_encode
    import posit_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      in_valid,
    input  unpacked_t sum,
    input  logic      sticky,
    output logic      out_valid,
    output posit_t    result,
    output logic      zero,
    output logic      nar
);

    localparam int NB = `POSIT_NBITS;
    localparam int ES = `POSIT_ES;
    localparam int FB = `ACC_FBITS;
    localparam int SB = `ACC_SBITS;
    localparam int MS = `POSIT_MAX_SCALE;
    localparam int SW = NB + ES + FB;    // Regime field, exponent, fraction
    localparam int OW = $clog2(NB);

    logic signed [SB-1:0] sc;
    logic signed [SB-1:0] rg;
    logic [ES-1:0]        ex;
    logic [FB-1:0]        fr;
    logic [OW-1:0]        off;
    logic [SW-1:0]        str;
    logic [NB-2:0]        body;
    logic                 guard;
    logic                 sticky_all;
    logic                 round_up;
    logic [NB-2:0]        body_r;
    posit_t               word;

    always_comb
    begin
        sc = sum.scale;
        fr = sum.fraction;

        // Out of range goes to exact maxpos or minpos
        if ($signed(sum.scale) > MS)
        begin
            sc = SB'(MS);
            fr = '0;
        end
        else if ($signed(sum.scale) < -MS)
        begin
            sc = -SB'(MS);
            fr = '0;
        end

        rg = sc >>> ES;
        ex = sc[ES-1:0];

        // Long regime run shifted left until only the regime length is left
        off = (rg < 0) ? OW'(NB - 1 + rg) : OW'(NB - 2 - rg);
        str = {{(NB - 1){~rg[SB-1]}}, rg[SB-1], ex, fr} << off;

        body       = str[SW-1 -: NB-1];
        guard      = str[SW-NB];
        sticky_all = |str[SW-NB-1:0] | sticky;

        // Ties to even and no rounding past an all-ones body
        round_up = guard & (body[0] | sticky_all) & ~&body;
        body_r   = body + {{(NB - 2){1'b0}}, round_up};

        word = sum.sign ? -{1'b0, body_r} : {1'b0, body_r};
        if (sum.nar)
            word = {1'b1, {(NB - 1){1'b0}}};
        else if (sum.zero)
            word = '0;
    end

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            out_valid <= 1'b0;
        else
            out_valid <= in_valid;
    end

    always_ff @(posedge clk)
    begin
        result <= word;
        zero   <= sum.zero;
        nar    <= sum.nar;
    end

endmodule

// ==== design/posit_accum_top.sv ====
// Posit accumulator top level
// Input register, decode, align, add, encode, with the running sum fed back

module posit_accum_top
    import posit_pkg::*;
(
    input  logic   clk,
    input  logic   rst,
    input  logic   start,
    input  posit_t operand,
    output posit_t result,
    output logic   zero,
    output logic   nar,
    output logic   done
);

    logic      in_valid;
    posit_t    in_word;
    logic      dec_valid;
    unpacked_t dec_value;
    logic      aln_valid;
    aligned_t  aln;
    logic      add_valid;
    unpacked_t add_sum;
    logic      add_sticky;
    unpacked_t acc_sum;
    logic      enc_valid;
    posit_t    enc_result;
    logic      enc_zero;
    logic      enc_nar;

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            in_valid <= 1'b0;
        else
            in_valid <= start;
    end

    always_ff @(posedge clk)
    begin
        if (start)
            in_word <= operand;
    end

    posit_decode u_decode (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (in_valid),
        .operand   (in_word),
        .out_valid (dec_valid),
        .value     (dec_value)
    );

    accum_align u_align (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (dec_valid),
        .operand   (dec_value),
        .sum       (acc_sum),
        .out_valid (aln_valid),
        .aligned   (aln)
    );

    accum_addsub u_addsub (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (aln_valid),
        .aligned   (aln),
        .out_valid (add_valid),
        .sum       (add_sum),
        .sticky    (add_sticky)
    );

    // Running sum, only reset clears it
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            acc_sum.sign     <= 1'b0;
            acc_sum.scale    <= '0;
            acc_sum.fraction <= '0;
            acc_sum.zero     <= 1'b1;
            acc_sum.nar      <= 1'b0;
        end
        else if (add_valid)
            acc_sum <= add_sum;
    end

    posit_encode u_encode (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (add_valid),
        .sum       (add_sum),
        .sticky    (add_sticky),
        .out_valid (enc_valid),
        .result    (enc_result),
        .zero      (enc_zero),
        .nar       (enc_nar)
    );

    // Output register, holds the last result between done pulses
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            done   <= 1'b0;
            result <= '0;
            zero   <= 1'b1;
            nar    <= 1'b0;
        end
        else
        begin
            done <= enc_valid;
            if (enc_valid)
            begin
                result <= enc_result;
                zero   <= enc_zero;
                nar    <= enc_nar;
            end
        end
    end

endmodule

// ==== tb/posit_accum_props.sv ====
// Posit accumulator protocol assertions
// Start spacing, done latency and output flags, bound to the top level

`include "posit_defs.svh"

module posit_accum_props (
    input logic clk,
    input logic rst,
    input logic start,
    input logic done,
    input logic zero,
    input logic nar
);

    timeunit 1ns;
    timeprecision 1ps;

    localparam int LAT = `ACC_LATENCY;

    // Only one accumulation may be in flight
    assert property (@(posedge clk) disable iff (rst)
        start |-> !($past(start, 1) || $past(start, 2) || $past(start, 3)
                    || $past(start, 4) || $past(start, 5)))
    else $error("start sampled again within five cycles of a start");

    // done is raised by edge LAT, seen one sample later
    assert property (@(posedge clk) disable iff (rst) done == $past(start, LAT + 1))
    else $error("done does not follow start by the pipeline latency");

    assert property (@(posedge clk) !(zero && nar))
    else $error("zero and nar high together");

    assert property (@(posedge clk) (rst || $past(rst)) |-> !done)
    else $error("done high during or right after reset");

endmodule

bind posit_accum_top posit_accum_props u_props (
    .clk   (clk),
    .rst   (rst),
    .start (start),
    .done  (done),
    .zero  (zero),
    .nar   (nar)
);

// ==== tb/posit_accum_tb.sv ====
// Posit accumulator testbench
// Directed tests checked against a fixed-point reference model of the posit format

`include "posit_defs.svh"

module posit_accum_tb
    import posit_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    // Fixed point with 64 integer bits and 16 fraction bits
    typedef logic signed [79:0] fix_t;

    localparam int CLK_PERIOD = 20;
    localparam int RESET_CYCLES = 5;
    localparam int INT_COUNT = 12;
    localparam int RAND_COUNT = 100;
    localparam int TOTAL_STARTS = 1 + INT_COUNT + 2 + RAND_COUNT + 5;
    localparam int WATCHDOG_CYCLES = TOTAL_STARTS * (`ACC_LATENCY + 4) + 200;
    localparam int INT_STEPS [INT_COUNT] = '{3, -7, 12, 100, -250, 5, -1, 64, 1000, -999, 17, 56};

    logic        clk;
    logic        rst;
    logic        start;
    posit_t      operand;
    posit_t      result;
    logic        zero;
    logic        nar;
    logic        done;
    logic [31:0] rng_state = 32'd98;

    posit_accum_top dut (
        .clk     (clk),
        .rst     (rst),
        .start   (start),
        .operand (operand),
        .result  (result),
        .zero    (zero),
        .nar     (nar),
        .done    (done)
    );

    initial
    begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial
    begin
        #(CLK_PERIOD * WATCHDOG_CYCLES);
        fail_run("Watchdog expired before all tests finished");
    end

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("test failed");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic check_value(input string name, input logic [79:0] expected,
                               input logic [79:0] actual);
        if (actual !== expected)
            fail_run($sformatf("MISMATCH time=%0t signal=%s expected=%0h actual=%0h",
                               $time, name, expected, actual));
    endtask

    function automatic logic [31:0] next_rand();
        logic [31:0] x;
        x = rng_state;
        x ^= x << 13;
        x ^= x >> 17;
        x ^= x << 5;
        rng_state = x;
        return x;
    endfunction

    // Reference encoder builds the regime, exponent and fraction string and rounds it to even
    function automatic posit_t fix_to_posit(input fix_t x);
        logic [79:0]  mag;
        logic [159:0] bits;
        logic [30:0]  body;
        logic         guard;
        logic         sticky;
        int           top;
        int           sc;
        int           k;
        int           e;
        int           pos;
        if (x == 0)
            return '0;
        mag = (x < 0) ? -x : x;
        top = 79;
        while (!mag[top])
            top--;
        sc   = top - 16;
        k    = sc >>> 2;             // Floor for negative scales too
        e    = sc - 4 * k;
        bits = '0;
        pos  = 159;
        if (k >= 0)
        begin
            for (int i = 0; i <= k; i++)
            begin
                bits[pos] = 1'b1;
                pos--;
            end
            pos--;                   // Terminating zero
        end
        else
        begin
            pos       = pos + k;     // Run of -k zeros
            bits[pos] = 1'b1;
            pos--;
        end
        bits[pos]     = e[1];
        bits[pos - 1] = e[0];
        pos           = pos - 2;
        for (int i = top - 1; i >= 0; i--)
        begin
            bits[pos] = mag[i];
            pos--;
        end
        body   = bits[159:129];
        guard  = bits[128];
        sticky = |bits[127:0];
        // Saturates at maxpos and never falls to zero
        if (guard && (body[0] || sticky) && body != '1)
            body = body + 1'b1;
        if (body == '0)
            body = 31'd1;
        return (x < 0) ? -{1'b0, body} : {1'b0, body};
    endfunction

    function automatic fix_t posit_to_fix(input posit_t w);
        posit_t mag;
        fix_t   mant;
        logic   first;
        int     i;
        int     run;
        int     k;
        int     e;
        int     sh;
        if (w == '0)
            return '0;
        mag   = w[31] ? -w : w;
        first = mag[30];
        i     = 30;
        run   = 0;
        while (i >= 0 && mag[i] == first)
        begin
            run++;
            i--;
        end
        k = first ? run - 1 : -run;
        i--;                         // Skip the terminating bit
        e = 0;
        repeat (2)
        begin
            e = 2 * e + ((i >= 0) ? int'(mag[i]) : 0);
            i--;
        end
        mant = 1;
        for (int j = i; j >= 0; j--)
            mant = (mant <<< 1) | fix_t'(mag[j]);
        sh = 4 * k + e - ((i >= 0) ? i + 1 : 0) + 16;
        if (sh >= 0)
            mant = mant <<< sh;
        else
            mant = mant >>> (-sh);
        return w[31] ? -mant : mant;
    endfunction

    // Magnitude between 2^-16 and 2^40 with a random sign, exact in fixed point
    function automatic posit_t random_operand();
        fix_t        mag;
        fix_t        mask;
        int          top;
        logic [31:0] hi;
        logic [31:0] lo;
        top  = int'(next_rand() % 56);
        hi   = next_rand();
        lo   = next_rand();
        mask = (fix_t'(1) <<< top) - 1;
        mag  = (fix_t'({hi, lo}) & mask) | (fix_t'(1) <<< top);
        if ((next_rand() & 32'd1) != 0)
            mag = -mag;
        return fix_to_posit(mag);
    endfunction

    task automatic reset_dut();
        rst     = 1'b1;
        start   = 1'b0;
        operand = '0;
        repeat (RESET_CYCLES) @(negedge clk);
        rst = 1'b0;
    endtask

    // Starts on a falling edge and returns on the falling edge where done is high
    task automatic issue_start(input posit_t word);
        int cycles;
        cycles  = 0;
        start   = 1'b1;
        operand = word;
        @(negedge clk);
        start = 1'b0;
        while (!done && cycles < `ACC_LATENCY + 4)
        begin
            @(negedge clk);
            cycles++;
        end
        if (!done)
            fail_run("done never rose after a start");
        else
            check_value("done_latency", `ACC_LATENCY, cycles);
    endtask

    task automatic expect_outputs(input posit_t word, input logic z, input logic n);
        check_value("result", word, result);
        check_value("zero", z, zero);
        check_value("nar", n, nar);
    endtask

    task automatic idle_after_reset();
        reset_dut();
        repeat (20)
        begin
            @(negedge clk);
            check_value("done", 1'b0, done);
        end
        expect_outputs('0, 1'b1, 1'b0);
    endtask

    task automatic single_start_latency();
        reset_dut();
        check_value("ref_one", 32'h4000_0000, fix_to_posit(fix_t'(1) <<< 16));
        issue_start(32'h4000_0000);
        expect_outputs(32'h4000_0000, 1'b0, 1'b0);
    endtask

    task automatic integer_sums();
        fix_t acc;
        fix_t step;
        acc = 0;
        reset_dut();
        for (int i = 0; i < INT_COUNT; i++)
        begin
            step = fix_t'(INT_STEPS[i]) <<< 16;
            acc  = acc + step;
            issue_start(fix_to_posit(step));
            expect_outputs(fix_to_posit(acc), acc == 0, 1'b0);
        end
    endtask

    task automatic cancel_to_zero();
        fix_t x;
        x = fix_t'(811008);          // 12.375
        reset_dut();
        issue_start(fix_to_posit(x));
        expect_outputs(fix_to_posit(x), 1'b0, 1'b0);
        issue_start(fix_to_posit(-x));
        expect_outputs('0, 1'b1, 1'b0);
    endtask

    // The running sum stays exact so each result must match the reference rounding
    task automatic random_rounding();
        fix_t   acc;
        posit_t w;
        acc = 0;
        reset_dut();
        for (int i = 0; i < RAND_COUNT; i++)
        begin
            w   = random_operand();
            acc = acc + posit_to_fix(w);
            issue_start(w);
            expect_outputs(fix_to_posit(acc), acc == 0, 1'b0);
        end
    endtask

    task automatic nar_is_sticky();
        reset_dut();
        issue_start(fix_to_posit(fix_t'(5) <<< 16));
        expect_outputs(fix_to_posit(fix_t'(5) <<< 16), 1'b0, 1'b0);
        issue_start(32'h8000_0000);
        expect_outputs(32'h8000_0000, 1'b0, 1'b1);
        issue_start(fix_to_posit(fix_t'(3) <<< 16));
        expect_outputs(32'h8000_0000, 1'b0, 1'b1);
        issue_start(fix_to_posit(fix_t'(-2) <<< 16));
        expect_outputs(32'h8000_0000, 1'b0, 1'b1);
        reset_dut();
        expect_outputs('0, 1'b1, 1'b0);   // Only reset clears NaR
        issue_start(fix_to_posit(fix_t'(3) <<< 16));
        expect_outputs(fix_to_posit(fix_t'(3) <<< 16), 1'b0, 1'b0);
    endtask

    initial
    begin
        rst     = 1'b1;
        start   = 1'b0;
        operand = '0;
        idle_after_reset();
        single_start_latency();
        integer_sums();
        cancel_to_zero();
        random_rounding();
        nar_is_sticky();
        $display("test passed");
        $finish;
    end

endmodule

// ==== sim.f ====
+incdir+common
common/posit_pkg.sv
design/posit_decode.sv
accum/accum_align.sv
accum/accum_addsub.sv
design/posit_encode.sv
design/posit_accum_top.sv
tb/posit_accum_props.sv
tb/posit_accum_tb.sv

// ==== Makefile ====
VERILATOR  ?= verilator
TOP        ?= posit_accum_tb
FLIST      ?= sim.f
BUILD_DIR  ?= obj_dir
TIMESCALE  ?= 1ns/1ps
VFLAGS     ?= --binary --timing --assert -Wno-fatal
LINT_FLAGS ?= --lint-only --timing -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --timescale $(TIMESCALE) --top-module $(TOP) \
		-f $(FLIST) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINT_FLAGS) --timescale $(TIMESCALE) --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf $(BUILD_DIR)
